//--- tankArena.f
+incdir+include
hw/arenaPkg.sv
hw/tileMapRom.sv
hw/tankSprite.sv
hw/tankMotion.sv
hw/arenaRenderer.sv
hw/tankArena.sv
sim/tankArenaTb.sv

//--- runSim.sh
#!/bin/sh
# build the arena testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tankArenaTb \
    -f tankArena.f -o tankArenaSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

simOut=$(./obj_dir/tankArenaSim 2>&1)
status=$?
printf '%s\n' "$simOut"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

//--- include/arenaModel.svh
`ifndef ARENA_MODEL_SVH
`define ARENA_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// reference model of map, palette, sprite and frame motion
//////////////////////////////////////////////////////////////////////

// tile index of a coordinate, folded onto count tiles
function automatic int tileIndex(input logic [9:0] a, input int count);
    return (int'(a) >> arenaPkg::tileShift) % count;
endfunction

function automatic logic [3:0] mapCode(input int col, input int row);
    // past the map edge reads as water
    if ((col >= arenaPkg::mapCols) || (row >= arenaPkg::mapRows))
    begin
        return 4'd0;
    end
    return arenaPkg::tileArenaMap[4'(row)][5'(col)];
endfunction

function automatic logic [11:0] paletteColour(input logic [3:0] code);
    case (code)
        4'd0:    return 12'h00F;
        4'd1:    return 12'h444;
        4'd2:    return 12'hF00;
        4'd3:    return 12'hFF0;
        default: return 12'h888;
    endcase
endfunction

// btn is {up, down, left, right}
function automatic logic [11:0] spriteColour(input logic [9:0] offX, input logic [9:0] offY,
                                             input logic [3:0] btn);
    int ox;
    int oy;
    int sx;
    int sy;
    int span;
    ox = int'(offX);
    oy = int'(offY);
    span = int'(arenaPkg::tankSize);
    // down beats left, left beats right
    if (btn[2])
    begin
        sx = span - (ox % span);
        sy = span - (oy % span);
    end
    else if (btn[1])
    begin
        sx = oy;
        sy = ox;
    end
    else if (btn[0])
    begin
        sx = span - (oy % span);
        sy = span - (ox % span);
    end
    else
    begin
        sx = ox;
        sy = oy;
    end
    if ((sx <= 5) || (sx >= 25))
    begin
        return 12'h555;
    end
    if ((sx >= 13) && (sx <= 17) && (sy <= 12))
    begin
        return 12'hFFF;
    end
    return 12'h0C0;
endfunction

// inclusive 31 pixel box, edges wrap at 1024
function automatic logic insideBox(input logic [9:0] px, input logic [9:0] py,
                                   input logic [9:0] posX, input logic [9:0] posY);
    logic [9:0] farX;
    logic [9:0] farY;
    farX = posX + arenaPkg::tankSize;
    farY = posY + arenaPkg::tankSize;
    return (px >= posX) && (px <= farX) && (py >= posY) && (py <= farY);
endfunction

function automatic logic [11:0] pixelColour(input logic ena, input logic [9:0] px,
                                            input logic [9:0] py, input logic [9:0] posX,
                                            input logic [9:0] posY, input logic [3:0] btn);
    if (!ena)
    begin
        return 12'h000;
    end
    if ((px > 10'd640) || (py > 10'd480))
    begin
        return 12'h222;
    end
    if (insideBox(px, py, posX, posY))
    begin
        return spriteColour(px - posX, py - posY, btn);
    end
    return paletteColour(mapCode(tileIndex(px, arenaPkg::mapCols),
                                 tileIndex(py, arenaPkg::mapRows)));
endfunction

function automatic logic blocks(input logic [3:0] code);
    return (code == 4'd1) || (code == 4'd2);
endfunction

// one frame-end update, flags tell which rules fired
function automatic void stepMotion(input logic [9:0] x, input logic [9:0] y,
                                   input logic [3:0] btn,
                                   output logic [9:0] nx, output logic [9:0] ny,
                                   output logic pushed, output logic wrapX,
                                   output logic wrapY);
    logic [9:0] mx;
    logic [9:0] my;
    int nearCol;
    int farCol;
    int nearRow;
    int farRow;
    logic c1;
    logic c2;
    logic c3;
    logic c4;
    mx = x;
    my = y;
    wrapX = 1'b0;
    wrapY = 1'b0;
    pushed = 1'b0;
    // edge wrap, Y first then X
    if (y == 10'd0)
    begin
        my = 10'd450;
        wrapY = 1'b1;
    end
    else if (y == 10'd450)
    begin
        my = 10'd0;
        wrapY = 1'b1;
    end
    if (x == 10'd0)
    begin
        mx = 10'd610;
        wrapX = 1'b1;
    end
    else if (x == 10'd610)
    begin
        mx = 10'd0;
        wrapX = 1'b1;
    end
    // every held button adds its own step
    my = btn[3] ? my - 10'd1 : my;
    my = btn[2] ? my + 10'd1 : my;
    mx = btn[1] ? mx - 10'd1 : mx;
    mx = btn[0] ? mx + 10'd1 : mx;
    nearCol = tileIndex(mx, arenaPkg::mapCols);
    farCol  = tileIndex(mx + arenaPkg::cornerReach, arenaPkg::mapCols);
    nearRow = tileIndex(my, arenaPkg::mapRows);
    farRow  = tileIndex(my + arenaPkg::cornerReach, arenaPkg::mapRows);
    c1 = blocks(mapCode(nearCol, nearRow));
    c2 = blocks(mapCode(farCol, nearRow));
    c3 = blocks(mapCode(nearCol, farRow));
    c4 = blocks(mapCode(farCol, farRow));
    nx = mx;
    ny = my;
    pushed = c1 || c2 || c3 || c4;
    if (c1 || c2)
    begin
        ny = my - 10'd1;
    end
    else if (c1 || c3)
    begin
        nx = mx + 10'd1;
    end
    else if (c3 || c4)
    begin
        ny = my + 10'd1;
    end
    else if (c2 || c4)
    begin
        nx = mx - 10'd1;
    end
endfunction

`endif

//--- sim/tankArenaTb.sv
`default_nettype none

module tankArenaTb;

    localparam int clkPeriod     = 4;
    localparam int resetCycles   = 5;
    localparam int blankCycles   = 40;
    localparam int outsideCycles = 100;
    localparam int paletteCycles = 300;
    localparam int spriteCycles  = 300;
    localparam int minFrames     = 20;
    localparam int maxFrames     = 400;
    localparam int probeCount    = 5;
    // every phase at its longest plus drain and slack cycles
    localparam int totalCycles   = resetCycles + blankCycles + 3 + outsideCycles
                                   + paletteCycles + 4 + spriteCycles + 4
                                   + maxFrames * (1 + probeCount) + 8;
    localparam int watchdogTime  = totalCycles * clkPeriod + 100 * clkPeriod;

    logic Master_Clock_In;
    logic rstN;
    logic dispEna;
    arenaPkg::coordT pixelX;
    arenaPkg::coordT pixelY;
    logic up;
    logic down;
    logic left;
    logic right;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;

    // colour for the pixel now in the DUT, and for the one now on its outputs
    logic checkOn;
    arenaPkg::colourT pendColour;
    arenaPkg::colourT expColour;
    // model tank position and motion coverage
    arenaPkg::coordT modelX;
    arenaPkg::coordT modelY;
    logic sawPush;
    logic sawWrapX;
    logic sawWrapY;

    `include "arenaModel.svh"

    tankArena u_dut
    (
        .Master_Clock_In (Master_Clock_In),
        .rstN            (rstN),
        .dispEna         (dispEna),
        .pixelX          (pixelX),
        .pixelY          (pixelY),
        .up              (up),
        .down            (down),
        .left            (left),
        .right           (right),
        .red             (red),
        .green           (green),
        .blue            (blue)
    );

    initial
    begin
        Master_Clock_In = 1'b0;
        forever #(clkPeriod / 2) Master_Clock_In = ~Master_Clock_In;
    end

    //////////////////////////////////////////////////////////////////////
    // failure reporting and output checks
    //////////////////////////////////////////////////////////////////////

    task automatic failRun(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic reportMismatch(input string chan, input logic [3:0] got,
                                  input logic [3:0] want);
        $display("MISMATCH at time %0t: %s is %h, expected %h", $time, chan, got, want);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    // each channel against the colour of the pixel driven one cycle back
    redMatch: assert property (@(posedge Master_Clock_In) disable iff (!checkOn)
                               red == expColour[11:8])
        else reportMismatch("red", $sampled(red), $sampled(expColour[11:8]));
    greenMatch: assert property (@(posedge Master_Clock_In) disable iff (!checkOn)
                                 green == expColour[7:4])
        else reportMismatch("green", $sampled(green), $sampled(expColour[7:4]));
    blueMatch: assert property (@(posedge Master_Clock_In) disable iff (!checkOn)
                                blue == expColour[3:0])
        else reportMismatch("blue", $sampled(blue), $sampled(expColour[3:0]));

    initial
    begin
        #(watchdogTime);
        failRun("watchdog expired before the tests finished");
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // one pixel per falling edge and a model step on an enabled frame end
    task automatic driveCycle(input logic ena, input arenaPkg::coordT px,
                              input arenaPkg::coordT py, input logic [3:0] btn);
        arenaPkg::coordT nx;
        arenaPkg::coordT ny;
        logic pushed;
        logic wx;
        logic wy;
        @(negedge Master_Clock_In);
        // outputs now show the pixel driven on the previous edge
        expColour = pendColour;
        dispEna = ena;
        pixelX = px;
        pixelY = py;
        {up, down, left, right} = btn;
        // colour uses the old position since a new one shows from the next cycle
        pendColour = pixelColour(ena, px, py, modelX, modelY, btn);
        if (ena && (px == 10'd640) && (py == 10'd480))
        begin
            stepMotion(modelX, modelY, btn, nx, ny, pushed, wx, wy);
            modelX = nx;
            modelY = ny;
            sawPush = sawPush | pushed;
            sawWrapX = sawWrapX | wx;
            sawWrapY = sawWrapY | wy;
        end
    endtask

    function automatic logic [3:0] anyButtons();
        return 4'($urandom_range(15, 0));
    endfunction

    // up and left held twice as often so the tank drifts into the brick rows
    function automatic logic [3:0] driftButtons();
        logic [3:0] btn;
        btn[3] = ($urandom_range(1, 0) == 1);
        btn[2] = ($urandom_range(3, 0) == 0);
        btn[1] = ($urandom_range(1, 0) == 1);
        btn[0] = ($urandom_range(3, 0) == 0);
        return btn;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // test phases
    //////////////////////////////////////////////////////////////////////

    task automatic blankingPhase();
        int i;
        for (i = 0; i < blankCycles; i++)
        begin
            driveCycle(1'b0, 10'($urandom), 10'($urandom), anyButtons());
        end
        // a blanked frame end must leave the tank at the origin
        driveCycle(1'b0, 10'd640, 10'd480, 4'b0101);
        driveCycle(1'b1, 10'd0, 10'd0, 4'b0000);
        driveCycle(1'b1, 10'd31, 10'd31, 4'b0000);
    endtask

    task automatic outsideFill();
        int i;
        arenaPkg::coordT px;
        arenaPkg::coordT py;
        for (i = 0; i < outsideCycles; i++)
        begin
            px = 10'($urandom);
            py = 10'($urandom);
            // push one axis past its limit
            if ($urandom_range(1, 0) == 1)
            begin
                px = 10'($urandom_range(1023, 641));
            end
            else
            begin
                py = 10'($urandom_range(1023, 481));
            end
            driveCycle(1'b1, px, py, anyButtons());
        end
    endtask

    task automatic paletteSweep();
        int i;
        arenaPkg::coordT px;
        arenaPkg::coordT py;
        for (i = 0; i < paletteCycles; i++)
        begin
            do
            begin
                px = 10'($urandom_range(640, 0));
                py = 10'($urandom_range(480, 0));
            end
            while (insideBox(px, py, modelX, modelY));
            driveCycle(1'b1, px, py, anyButtons());
        end
        // one pixel in each water border
        driveCycle(1'b1, 10'd100, 10'd10, 4'b0000);
        driveCycle(1'b1, 10'd100, 10'd470, 4'b0000);
        driveCycle(1'b1, 10'd5, 10'd200, 4'b0000);
        driveCycle(1'b1, 10'd630, 10'd200, 4'b0000);
    endtask

    task automatic spriteSweep();
        int i;
        for (i = 0; i < spriteCycles; i++)
        begin
            driveCycle(1'b1, modelX + 10'($urandom_range(30, 0)),
                       modelY + 10'($urandom_range(30, 0)), anyButtons());
        end
        // inclusive corners of the box
        driveCycle(1'b1, modelX, modelY, anyButtons());
        driveCycle(1'b1, modelX + 10'd30, modelY, anyButtons());
        driveCycle(1'b1, modelX, modelY + 10'd30, anyButtons());
        driveCycle(1'b1, modelX + 10'd30, modelY + 10'd30, anyButtons());
    endtask

    task automatic frameMotion();
        int frame;
        frame = 0;
        while ((frame < maxFrames)
               && !((frame >= minFrames) && sawPush && sawWrapX && sawWrapY))
        begin
            driveCycle(1'b1, 10'd640, 10'd480, driftButtons());
            // probes on and just past the new box edges
            driveCycle(1'b1, modelX, modelY, anyButtons());
            driveCycle(1'b1, modelX + 10'd30, modelY + 10'd30, anyButtons());
            driveCycle(1'b1, modelX - 10'd1, modelY, anyButtons());
            driveCycle(1'b1, modelX, modelY - 10'd1, anyButtons());
            driveCycle(1'b1, modelX + 10'd31, modelY + 10'd15, anyButtons());
            frame++;
        end
    endtask

    initial
    begin
        void'($urandom(32'h25b494b7));
        rstN = 1'b0;
        // reset must clear the colour register while an in-area pixel is shown
        dispEna = 1'b1;
        pixelX = 10'd100;
        pixelY = 10'd10;
        up = 1'b0;
        down = 1'b0;
        left = 1'b0;
        right = 1'b0;
        checkOn = 1'b0;
        pendColour = '0;
        expColour = '0;
        modelX = '0;
        modelY = '0;
        sawPush = 1'b0;
        sawWrapX = 1'b0;
        sawWrapY = 1'b0;
        repeat (resetCycles) @(negedge Master_Clock_In);
        rstN = 1'b1;
        dispEna = 1'b0;
        // outputs hold the reset value from here on
        checkOn = 1'b1;
        blankingPhase();
        outsideFill();
        paletteSweep();
        spriteSweep();
        frameMotion();
        // drain so the last probe reaches the checks
        driveCycle(1'b0, 10'd0, 10'd0, 4'b0000);
        driveCycle(1'b0, 10'd0, 10'd0, 4'b0000);
        @(negedge Master_Clock_In);
        if (sawPush && sawWrapX && sawWrapY)
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
        else
        begin
            failRun("frame motion never reached a push-back and both wraps");
        end
    end

endmodule

`default_nettype wire

//--- hw/tankArena.sv
`default_nettype none

module tankArena
(
    input  logic            Master_Clock_In,
    input  logic            rstN,
    input  logic            dispEna,
    input  arenaPkg::coordT pixelX,
    input  arenaPkg::coordT pixelY,
    input  logic            up,
    input  logic            down,
    input  logic            left,
    input  logic            right,
    output logic [3:0]      red,
    output logic [3:0]      green,
    output logic [3:0]      blue
);

    // tank position, updated at frame end, read by the renderer
    arenaPkg::coordT posX;
    arenaPkg::coordT posY;

    //////////////////////////////////////////////////////////////////////
    // motion and drawing
    //////////////////////////////////////////////////////////////////////

    tankMotion u_motion
    (
        .Master_Clock_In (Master_Clock_In),
        .rstN            (rstN),
        .dispEna         (dispEna),
        .up              (up),
        .down            (down),
        .left            (left),
        .right           (right),
        .pixelX          (pixelX),
        .pixelY          (pixelY),
        .posX            (posX),
        .posY            (posY)
    );

    // buttons also pick the sprite orientation
    arenaRenderer u_renderer
    (
        .Master_Clock_In (Master_Clock_In),
        .rstN            (rstN),
        .dispEna         (dispEna),
        .up              (up),
        .down            (down),
        .left            (left),
        .right           (right),
        .pixelX          (pixelX),
        .pixelY          (pixelY),
        .posX            (posX),
        .posY            (posY),
        .red             (red),
        .green           (green),
        .blue            (blue)
    );

endmodule

`default_nettype wire

//--- hw/arenaRenderer.sv
`default_nettype none

module arenaRenderer
(
    input  logic            Master_Clock_In,
    input  logic            rstN,
    input  logic            dispEna,
    input  logic            up,
    input  logic            down,
    input  logic            left,
    input  logic            right,
    input  arenaPkg::coordT pixelX,
    input  arenaPkg::coordT pixelY,
    input  arenaPkg::coordT posX,
    input  arenaPkg::coordT posY,
    output logic [3:0]      red,
    output logic [3:0]      green,
    output logic [3:0]      blue
);

    // pixel relative to the tank and the far box edges
    arenaPkg::coordT offsetX;
    arenaPkg::coordT offsetY;
    arenaPkg::coordT boxRight;
    arenaPkg::coordT boxBottom;
    logic inArea;
    logic inBox;

    // tile under the current pixel
    logic [4:0] pixCol;
    logic [3:0] pixRow;
    arenaPkg::tileCodeT pixCode;

    arenaPkg::colourT tileColour;
    arenaPkg::colourT tankColour;
    arenaPkg::colourT nextColour;
    arenaPkg::colourT colourQ;

    //////////////////////////////////////////////////////////////////////
    // area and tank box tests
    //////////////////////////////////////////////////////////////////////

    assign inArea    = (pixelX <= arenaPkg::screenWidth) && (pixelY <= arenaPkg::screenHeight);
    assign boxRight  = posX + arenaPkg::tankSize;
    assign boxBottom = posY + arenaPkg::tankSize;
    assign inBox     = (pixelX >= posX) && (pixelX <= boxRight)
                       && (pixelY >= posY) && (pixelY <= boxBottom);
    assign offsetX   = pixelX - posX;
    assign offsetY   = pixelY - posY;

    tankSprite u_sprite
    (
        .offsetX      (offsetX),
        .offsetY      (offsetY),
        .up           (up),
        .down         (down),
        .left         (left),
        .right        (right),
        .spriteColour (tankColour)
    );

    //////////////////////////////////////////////////////////////////////
    // map palette
    //////////////////////////////////////////////////////////////////////

    assign pixCol = arenaPkg::tileColOf(pixelX);
    assign pixRow = arenaPkg::tileRowOf(pixelY);

    tileMapRom u_pixelTile (.tileCol(pixCol), .tileRow(pixRow), .tileCode(pixCode));

    always_comb
    begin
        case (pixCode)
            arenaPkg::codeWater: tileColour = arenaPkg::waterColour;
            arenaPkg::codeWall:  tileColour = arenaPkg::wallColour;
            arenaPkg::codeBrick: tileColour = arenaPkg::brickColour;
            arenaPkg::codeSand:  tileColour = arenaPkg::sandColour;
            default:             tileColour = arenaPkg::unknownColour;
        endcase
    end

    // blanking beats area fill, area fill beats tank, tank beats map
    always_comb
    begin
        if (!dispEna)
        begin
            nextColour = arenaPkg::blankColour;
        end
        else if (!inArea)
        begin
            nextColour = arenaPkg::outsideColour;
        end
        else if (inBox)
        begin
            nextColour = tankColour;
        end
        else
        begin
            nextColour = tileColour;
        end
    end

    // one cycle from pixel to colour
    always_ff @(posedge Master_Clock_In)
    begin
        if (!rstN)
        begin
            colourQ <= arenaPkg::blankColour;
        end
        else
        begin
            colourQ <= nextColour;
        end
    end

    assign red   = colourQ[11:8];
    assign green = colourQ[7:4];
    assign blue  = colourQ[3:0];

endmodule

`default_nettype wire

//--- hw/tankMotion.sv
`default_nettype none

module tankMotion
(
    input  logic            Master_Clock_In,
    input  logic            rstN,
    input  logic            dispEna,
    input  logic            up,
    input  logic            down,
    input  logic            left,
    input  logic            right,
    input  arenaPkg::coordT pixelX,
    input  arenaPkg::coordT pixelY,
    output arenaPkg::coordT posX,
    output arenaPkg::coordT posY
);

    logic frameEnd;

    // position after wrap, after button moves, and after push-back
    arenaPkg::coordT wrapX;
    arenaPkg::coordT wrapY;
    arenaPkg::coordT movedX;
    arenaPkg::coordT movedY;
    arenaPkg::coordT nextX;
    arenaPkg::coordT nextY;

    // far corner coordinates and the four corner tiles
    arenaPkg::coordT farX;
    arenaPkg::coordT farY;
    logic [4:0] nearCol;
    logic [4:0] farCol;
    logic [3:0] nearRow;
    logic [3:0] farRow;
    arenaPkg::tileCodeT code1;
    arenaPkg::tileCodeT code2;
    arenaPkg::tileCodeT code3;
    arenaPkg::tileCodeT code4;
    logic block1;
    logic block2;
    logic block3;
    logic block4;

    // wall and brick stop the tank, water and sand do not
    function automatic logic isBlocking(input arenaPkg::tileCodeT code);
        return (code == arenaPkg::codeWall) || (code == arenaPkg::codeBrick);
    endfunction

    // last pixel of the frame, only while the display is enabled
    assign frameEnd = dispEna && (pixelX == arenaPkg::screenWidth)
                      && (pixelY == arenaPkg::screenHeight);

    //////////////////////////////////////////////////////////////////////
    // edge wrap then button moves
    //////////////////////////////////////////////////////////////////////

    assign wrapY = (posY == '0) ? arenaPkg::wrapLimitY
                 : (posY == arenaPkg::wrapLimitY) ? '0 : posY;
    assign wrapX = (posX == '0) ? arenaPkg::wrapLimitX
                 : (posX == arenaPkg::wrapLimitX) ? '0 : posX;

    always_comb
    begin
        movedX = wrapX;
        movedY = wrapY;
        // each button adds its own single pixel step
        if (up)
        begin
            movedY = movedY - 10'd1;
        end
        if (down)
        begin
            movedY = movedY + 10'd1;
        end
        if (left)
        begin
            movedX = movedX - 10'd1;
        end
        if (right)
        begin
            movedX = movedX + 10'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // collision corners
    //////////////////////////////////////////////////////////////////////

    assign farX    = movedX + arenaPkg::cornerReach;
    assign farY    = movedY + arenaPkg::cornerReach;
    assign nearCol = arenaPkg::tileColOf(movedX);
    assign farCol  = arenaPkg::tileColOf(farX);
    assign nearRow = arenaPkg::tileRowOf(movedY);
    assign farRow  = arenaPkg::tileRowOf(farY);

    // c1 near/near, c2 far/near, c3 near/far, c4 far/far
    tileMapRom u_corner1 (.tileCol(nearCol), .tileRow(nearRow), .tileCode(code1));
    tileMapRom u_corner2 (.tileCol(farCol),  .tileRow(nearRow), .tileCode(code2));
    tileMapRom u_corner3 (.tileCol(nearCol), .tileRow(farRow),  .tileCode(code3));
    tileMapRom u_corner4 (.tileCol(farCol),  .tileRow(farRow),  .tileCode(code4));

    assign block1 = isBlocking(code1);
    assign block2 = isBlocking(code2);
    assign block3 = isBlocking(code3);
    assign block4 = isBlocking(code4);

    // one push-back step, first matching edge wins
    always_comb
    begin
        nextX = movedX;
        nextY = movedY;
        if (block1 || block2)
        begin
            nextY = movedY - 10'd1;
        end
        else if (block1 || block3)
        begin
            nextX = movedX + 10'd1;
        end
        else if (block3 || block4)
        begin
            nextY = movedY + 10'd1;
        end
        else if (block2 || block4)
        begin
            nextX = movedX - 10'd1;
        end
    end

    // position only changes on the frame-end cycle
    always_ff @(posedge Master_Clock_In)
    begin
        if (!rstN)
        begin
            posX <= '0;
            posY <= '0;
        end
        else if (frameEnd)
        begin
            posX <= nextX;
            posY <= nextY;
        end
    end

endmodule

`default_nettype wire

//--- hw/tankSprite.sv
`default_nettype none

module tankSprite
(
    input  arenaPkg::coordT  offsetX,
    input  arenaPkg::coordT  offsetY,
    input  logic             up,
    input  logic             down,
    input  logic             left,
    input  logic             right,
    output arenaPkg::colourT spriteColour
);

    // sprite coordinates after turning for the pressed direction
    arenaPkg::coordT sx;
    arenaPkg::coordT sy;

    // flips a box offset end for end, 0 and 30 both land on 30
    function automatic arenaPkg::coordT mirrored(input arenaPkg::coordT a);
        return arenaPkg::tankSize - (a % arenaPkg::tankSize);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // orientation
    //////////////////////////////////////////////////////////////////////

    // the up sprite has the barrel at small sy, so up and no press
    // share the plain mapping
    always_comb
    begin
        if (down)
        begin
            sx = mirrored(offsetX);
            sy = mirrored(offsetY);
        end
        else if (left)
        begin
            // axes swapped, barrel toward small x
            sx = offsetY;
            sy = offsetX;
        end
        else if (right)
        begin
            sx = mirrored(offsetY);
            sy = mirrored(offsetX);
        end
        else
        begin
            // up is the plain mapping, covers no press as well
            sx = offsetX;
            sy = offsetY;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // shape
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // treads down both sides
        if ((sx <= arenaPkg::treadInner) || (sx >= arenaPkg::treadOuter))
        begin
            spriteColour = arenaPkg::treadColour;
        end
        // barrel runs from the front edge to the middle
        else if ((sx >= arenaPkg::barrelLeft) && (sx <= arenaPkg::barrelRight)
                 && (sy <= arenaPkg::barrelLength))
        begin
            spriteColour = arenaPkg::barrelColour;
        end
        else
        begin
            spriteColour = arenaPkg::bodyColour;
        end
    end

endmodule

`default_nettype wire

//--- hw/tileMapRom.sv
`default_nettype none

module tileMapRom
(
    input  logic [4:0]         tileCol,
    input  logic [3:0]         tileRow,
    output arenaPkg::tileCodeT tileCode
);

    //////////////////////////////////////////////////////////////////////
    // index checks
    //////////////////////////////////////////////////////////////////////

    // 5 bit column reaches 31 and 4 bit row reaches 15,
    // both past the edge of the map
    logic colInRange;
    logic rowInRange;

    // whole row of codes picked by the tile row
    arenaPkg::mapRowT rowData;

    assign colInRange = (tileCol < 5'(arenaPkg::mapCols));
    assign rowInRange = (tileRow < 4'(arenaPkg::mapRows));

    //////////////////////////////////////////////////////////////////////
    // row fetch
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // rows past the bottom read as water
        rowData = '0;
        if (rowInRange)
        begin
            rowData = arenaPkg::tileArenaMap[tileRow];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // column select
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // default is code 0, same as the border
        tileCode = arenaPkg::codeWater;
        if (colInRange)
        begin
            // nibble for this column, first nibble is the leftmost tile
            tileCode = rowData[tileCol];
        end
    end

endmodule

`default_nettype wire

//--- hw/arenaPkg.sv
`default_nettype none

package arenaPkg;

    //////////////////////////////////////////////////////////////////////
    // shared types
    //////////////////////////////////////////////////////////////////////

    // pixel coordinate, arithmetic on it wraps at 1024
    typedef logic [9:0]  coordT;
    typedef logic [3:0]  tileCodeT;
    // red nibble on top, then green, then blue
    typedef logic [11:0] colourT;

    //////////////////////////////////////////////////////////////////////
    // screen and tile geometry
    //////////////////////////////////////////////////////////////////////

    // visible area limits, both checked inclusively
    localparam coordT screenWidth  = 10'd640;
    localparam coordT screenHeight = 10'd480;
    // 32 pixel tiles on a 20 by 15 grid
    localparam int    tileShift    = 5;
    localparam int    mapCols      = 20;
    localparam int    mapRows      = 15;
    // sprite box spans position to position + tankSize inclusive
    localparam coordT tankSize     = 10'd30;
    // far collision corner sits this far from the position
    localparam coordT cornerReach  = 10'd20;
    // positions where the tank jumps to the opposite edge
    localparam coordT wrapLimitX   = screenWidth - tankSize;
    localparam coordT wrapLimitY   = screenHeight - tankSize;

    //////////////////////////////////////////////////////////////////////
    // tile codes and colours
    //////////////////////////////////////////////////////////////////////

    localparam tileCodeT codeWater = 4'd0;
    localparam tileCodeT codeWall  = 4'd1;
    localparam tileCodeT codeBrick = 4'd2;
    localparam tileCodeT codeSand  = 4'd3;

    localparam colourT waterColour   = 12'h00F;
    localparam colourT wallColour    = 12'h444;
    localparam colourT brickColour   = 12'hF00;
    localparam colourT sandColour    = 12'hFF0;
    localparam colourT unknownColour = 12'h888;
    localparam colourT outsideColour = 12'h222;
    localparam colourT blankColour   = 12'h000;

    // tank sprite colours and shape bounds in sprite coordinates
    localparam colourT treadColour  = 12'h555;
    localparam colourT barrelColour = 12'hFFF;
    localparam colourT bodyColour   = 12'h0C0;
    localparam coordT  treadInner   = 10'd5;
    localparam coordT  treadOuter   = 10'd25;
    localparam coordT  barrelLeft   = 10'd13;
    localparam coordT  barrelRight  = 10'd17;
    localparam coordT  barrelLength = 10'd12;

    //////////////////////////////////////////////////////////////////////
    // arena layout
    //////////////////////////////////////////////////////////////////////

    // one hex digit per tile, leftmost digit is column 0
    typedef logic [0:mapCols-1][3:0] mapRowT;

    // water border all round, brick and sand inside
    localparam mapRowT tileArenaMap [0:mapRows-1] = '{
        80'h00000000000000000000,
        80'h02323223233232232320,
        80'h03323333233233332330,
        80'h02222223233232222220,
        80'h03323333233233332330,
        80'h02323223222232232330,
        80'h03333333333333333330,
        80'h02222232222223222220,
        80'h03333333333333333330,
        80'h02323223222232232320,
        80'h03323333233233332330,
        80'h02222223233232222220,
        80'h03323333233233332330,
        80'h02323223233232232320,
        80'h00000000000000000000
    };

    // tile column and row that hold a coordinate, folded onto the map
    function automatic logic [4:0] tileColOf(input coordT a);
        return 5'((a >> tileShift) % mapCols);
    endfunction

    function automatic logic [3:0] tileRowOf(input coordT a);
        return 4'((a >> tileShift) % mapRows);
    endfunction

endpackage

`default_nettype wire
